// File: tcdm_pkg.sv
// Sizes, address layout and the bus structs shared by every block of the TCDM
// Memory spans 0x0000 to MEM_BYTES-1; any address with a nonzero hi field is an error
package tcdm_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////
  localparam int NB_BANKS    = 4;
  localparam int BANK_WORDS  = 256;
  localparam int BANK_SEL_W  = $clog2(NB_BANKS);
  localparam int BANK_ADDR_W = $clog2(BANK_WORDS);
  localparam int DATA_W      = 32;
  localparam int STRB_W      = DATA_W / 8;
  localparam int BYTE_W      = $clog2(STRB_W);
  localparam int AXI_ADDR_W  = 16;
  localparam int MEM_BYTES   = NB_BANKS * BANK_WORDS * STRB_W;
  // Address bits above the memory, all zero for a hit
  localparam int ADDR_HI_W   = AXI_ADDR_W - $clog2(MEM_BYTES);

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  //////////////////////////////////////////////////
  // Address views
  //////////////////////////////////////////////////
  // Word interleaved, so the bank index sits right above the byte lane
  typedef struct packed {
    logic [ADDR_HI_W-1:0]   hi;
    logic [BANK_ADDR_W-1:0] offset;
    logic [BANK_SEL_W-1:0]  bank;
    logic [BYTE_W-1:0]      byte_idx;
  } tcdm_addr_f_t;

  typedef union packed {
    logic [AXI_ADDR_W-1:0] raw;
    tcdm_addr_f_t          f;
  } tcdm_addr_u;

  //////////////////////////////////////////////////
  // AXI4-Lite channels
  //////////////////////////////////////////////////
  // Master side
  typedef struct packed {
    logic                  aw_valid;
    logic [AXI_ADDR_W-1:0] aw_addr;
    logic                  w_valid;
    logic [DATA_W-1:0]     w_data;
    logic [STRB_W-1:0]     w_strb;
    logic                  b_ready;
    logic                  ar_valid;
    logic [AXI_ADDR_W-1:0] ar_addr;
    logic                  r_ready;
  } axil_req_t;

  // Slave side
  typedef struct packed {
    logic              aw_ready;
    logic              w_ready;
    logic              b_valid;
    logic [1:0]        b_resp;
    logic              ar_ready;
    logic              r_valid;
    logic [DATA_W-1:0] r_data;
    logic [1:0]        r_resp;
  } axil_rsp_t;

  //////////////////////////////////////////////////
  // Memory side
  //////////////////////////////////////////////////
  typedef struct packed {
    logic              req;
    logic              we;
    logic [STRB_W-1:0] be;
    tcdm_addr_u        addr;
    logic [DATA_W-1:0] wdata;
  } tcdm_req_t;

  // One bank port, ce high for one cycle per access
  typedef struct packed {
    logic                   ce;
    logic                   we;
    logic [STRB_W-1:0]      be;
    logic [BANK_ADDR_W-1:0] offset;
    logic [DATA_W-1:0]      wdata;
  } bank_req_t;

  typedef struct packed {
    logic              valid;
    logic              err;
    logic [DATA_W-1:0] rdata;
  } tcdm_rsp_t;

endpackage

// File: tcdm_sram_bank.sv
// Single port bank, one cycle read latency, byte enabled writes
// rdata holds its value when idle or writing
`timescale 1ns/1ps

module tcdm_sram_bank (
  input  logic                             clk_i,
  input  logic                             ce,
  input  logic                             we,
  input  logic [tcdm_pkg::STRB_W-1:0]      be,
  input  logic [tcdm_pkg::BANK_ADDR_W-1:0] offset,
  input  logic [tcdm_pkg::DATA_W-1:0]      wdata,
  output logic [tcdm_pkg::DATA_W-1:0]      rdata
);

  // Storage
  logic [tcdm_pkg::DATA_W-1:0] mem [tcdm_pkg::BANK_WORDS];

  always_ff @(posedge clk_i)
  begin
    if (ce)
    begin
      if (we)
      begin
        // Only enabled lanes change
        for (int b = 0; b < tcdm_pkg::STRB_W; b++)
        begin
          if (be[b])
          begin
            mem[offset][b*8 +: 8] <= wdata[b*8 +: 8];
          end
        end
      end
      else
      begin
        rdata <= mem[offset];
      end
    end
  end

endmodule

// File: tcdm_banks_wrap.sv
// Array of NB_BANKS behavioural banks, contents start undefined
// No reset port, bank ports are unpacked here
`timescale 1ns/1ps

module tcdm_banks_wrap (
  input  logic                        clk_i,
  input  tcdm_pkg::bank_req_t         bank_req [tcdm_pkg::NB_BANKS],
  output logic [tcdm_pkg::DATA_W-1:0] bank_rdata [tcdm_pkg::NB_BANKS]
);

  for (genvar i = 0; i < tcdm_pkg::NB_BANKS; i++)
  begin : g_bank
    // Per bank port signals
    logic                             bank_ce;
    logic                             bank_we;
    logic [tcdm_pkg::STRB_W-1:0]      bank_be;
    logic [tcdm_pkg::BANK_ADDR_W-1:0] bank_a;
    logic [tcdm_pkg::DATA_W-1:0]      bank_d;
    logic [tcdm_pkg::DATA_W-1:0]      bank_q;

    assign bank_ce       = bank_req[i].ce;
    assign bank_we       = bank_req[i].we;
    assign bank_be       = bank_req[i].be;
    assign bank_a        = bank_req[i].offset;
    assign bank_d        = bank_req[i].wdata;
    assign bank_rdata[i] = bank_q;

    tcdm_sram_bank i_bank (
      .clk_i  ( clk_i   ),
      .ce     ( bank_ce ),
      .we     ( bank_we ),
      .be     ( bank_be ),
      .offset ( bank_a  ),
      .wdata  ( bank_d  ),
      .rdata  ( bank_q  )
    );
  end

endmodule

// File: tcdm_bank_sel.sv
// Bank decode and read return, fixed two cycles from req to rsp valid
// Out of range accesses enable no bank and return zero data with err set
`timescale 1ns/1ps

module tcdm_bank_sel (
  input  logic                              clk_i,
  input  logic                              arst_n,
  input  tcdm_pkg::tcdm_req_t               mem_req,
  output tcdm_pkg::tcdm_rsp_t               mem_rsp,
  output tcdm_pkg::bank_req_t               bank_req [tcdm_pkg::NB_BANKS],
  input  logic [tcdm_pkg::DATA_W-1:0]       bank_rdata [tcdm_pkg::NB_BANKS]
);

  logic                             in_range;
  logic [tcdm_pkg::NB_BANKS-1:0]    ce_d;

  // Stage one, bank access cycle
  logic [tcdm_pkg::NB_BANKS-1:0]    ce_q;
  logic                             pend_q;
  logic                             err_q;
  logic [tcdm_pkg::BANK_SEL_W-1:0]  idx_q;
  logic                             we_q;
  logic [tcdm_pkg::STRB_W-1:0]      be_q;
  logic [tcdm_pkg::BANK_ADDR_W-1:0] offset_q;
  logic [tcdm_pkg::DATA_W-1:0]      wdata_q;

  // Stage two, read return cycle
  logic                             vld_q;
  logic                             sel_err_q;
  logic [tcdm_pkg::BANK_SEL_W-1:0]  sel_idx_q;

  // Hit only when no bits above the memory are set
  assign in_range = (mem_req.addr.f.hi == '0);

  always_comb
  begin
    for (int i = 0; i < tcdm_pkg::NB_BANKS; i++)
    begin
      ce_d[i] = mem_req.req && in_range &&
                (mem_req.addr.f.bank == tcdm_pkg::BANK_SEL_W'(i));
    end
  end

  //////////////////////////////////////////////////
  // Pipeline registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ce_q      <= '0;
      pend_q    <= 1'b0;
      err_q     <= 1'b0;
      idx_q     <= '0;
      vld_q     <= 1'b0;
      sel_err_q <= 1'b0;
      sel_idx_q <= '0;
    end
    else
    begin
      ce_q      <= ce_d;
      pend_q    <= mem_req.req;
      if (mem_req.req)
      begin
        err_q <= !in_range;
        idx_q <= mem_req.addr.f.bank;
      end
      // Bank data arrives with this stage
      vld_q     <= pend_q;
      sel_err_q <= err_q;
      sel_idx_q <= idx_q;
    end
  end

  // Shared bank payload, gated by ce
  always_ff @(posedge clk_i)
  begin
    if (mem_req.req)
    begin
      we_q     <= mem_req.we;
      be_q     <= mem_req.be;
      offset_q <= mem_req.addr.f.offset;
      wdata_q  <= mem_req.wdata;
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////
  always_comb
  begin
    for (int i = 0; i < tcdm_pkg::NB_BANKS; i++)
    begin
      bank_req[i].ce     = ce_q[i];
      bank_req[i].we     = we_q;
      bank_req[i].be     = be_q;
      bank_req[i].offset = offset_q;
      bank_req[i].wdata  = wdata_q;
    end
  end

  assign mem_rsp.valid = vld_q;
  assign mem_rsp.err   = sel_err_q;
  assign mem_rsp.rdata = sel_err_q ? '0 : bank_rdata[sel_idx_q];

endmodule

// File: tcdm_axil_front.sv
// AXI4-Lite slave, one transaction in flight; protection bits are not used
// Ready depends on valid in idle, a write needs AW and W together
`timescale 1ns/1ps

module tcdm_axil_front (
  input  logic                clk_i,
  input  logic                arst_n,
  input  tcdm_pkg::axil_req_t axil_req,
  output tcdm_pkg::axil_rsp_t axil_rsp,
  output tcdm_pkg::tcdm_req_t mem_req,
  input  tcdm_pkg::tcdm_rsp_t mem_rsp
);

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_wait,
    st_resp
  } state_e;

  state_e state_q;
  state_e state_d;

  // Control
  logic is_wr_q;
  logic req_q;
  logic acc_wr;
  logic acc_rd;
  logic rsp_done;

  // Captured request payload
  logic                              we_q;
  logic [tcdm_pkg::STRB_W-1:0]       be_q;
  tcdm_pkg::tcdm_addr_u              addr_q;
  logic [tcdm_pkg::DATA_W-1:0]       wdata_q;

  // Captured response payload
  logic [1:0]                  resp_q;
  logic [tcdm_pkg::DATA_W-1:0] rdata_q;

  //////////////////////////////////////////////////
  // Acceptance
  //////////////////////////////////////////////////
  // Write has priority when both are pending
  assign acc_wr = (state_q == st_idle) && axil_req.aw_valid && axil_req.w_valid;
  assign acc_rd = (state_q == st_idle) && axil_req.ar_valid && !acc_wr;

  // Master took B or R
  assign rsp_done = (state_q == st_resp) &&
                    (is_wr_q ? axil_req.b_ready : axil_req.r_ready);

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      st_idle:
      begin
        if (acc_wr || acc_rd)
        begin
          state_d = st_issue;
        end
      end
      st_issue: state_d = st_wait;
      st_wait:
      begin
        if (mem_rsp.valid)
        begin
          state_d = st_resp;
        end
      end
      st_resp:
      begin
        if (rsp_done)
        begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q <= st_idle;
      is_wr_q <= 1'b0;
      req_q   <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // Request pulses for the one cycle after issue
      req_q   <= (state_q == st_issue);
      if (acc_wr || acc_rd)
      begin
        is_wr_q <= acc_wr;
      end
    end
  end

  // Payload capture, no reset needed
  always_ff @(posedge clk_i)
  begin
    if (acc_wr)
    begin
      we_q     <= 1'b1;
      be_q     <= axil_req.w_strb;
      addr_q   <= axil_req.aw_addr;
      wdata_q  <= axil_req.w_data;
    end
    else if (acc_rd)
    begin
      // Reads fetch the full word
      we_q     <= 1'b0;
      be_q     <= '1;
      addr_q   <= axil_req.ar_addr;
    end
    if ((state_q == st_wait) && mem_rsp.valid)
    begin
      resp_q  <= mem_rsp.err ? tcdm_pkg::RESP_DECERR : tcdm_pkg::RESP_OKAY;
      rdata_q <= mem_rsp.rdata;
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////
  assign mem_req.req   = req_q;
  assign mem_req.we    = we_q;
  assign mem_req.be    = be_q;
  assign mem_req.addr  = addr_q;
  assign mem_req.wdata = wdata_q;

  assign axil_rsp.aw_ready = acc_wr;
  assign axil_rsp.w_ready  = acc_wr;
  assign axil_rsp.ar_ready = acc_rd;
  // B and R held until taken
  assign axil_rsp.b_valid  = (state_q == st_resp) && is_wr_q;
  assign axil_rsp.b_resp   = resp_q;
  assign axil_rsp.r_valid  = (state_q == st_resp) && !is_wr_q;
  assign axil_rsp.r_data   = rdata_q;
  assign axil_rsp.r_resp   = resp_q;

endmodule

// File: tcdm_lite_top.sv
// TCDM with one AXI4-Lite slave port, 4 KB over four interleaved banks
// Four cycles from address handshake to B or R valid
`timescale 1ns/1ps

module tcdm_lite_top (
  input  logic                clk_i,
  input  logic                arst_n,
  input  tcdm_pkg::axil_req_t axil_req,
  output tcdm_pkg::axil_rsp_t axil_rsp
);

  // Front end to decoder
  tcdm_pkg::tcdm_req_t mem_req;
  tcdm_pkg::tcdm_rsp_t mem_rsp;

  // Decoder to bank array
  tcdm_pkg::bank_req_t         bank_req [tcdm_pkg::NB_BANKS];
  logic [tcdm_pkg::DATA_W-1:0] bank_rdata [tcdm_pkg::NB_BANKS];

  //////////////////////////////////////////////////
  // Pipeline stages
  //////////////////////////////////////////////////
  tcdm_axil_front i_front (
    .clk_i    ( clk_i    ),
    .arst_n   ( arst_n   ),
    .axil_req ( axil_req ),
    .axil_rsp ( axil_rsp ),
    .mem_req  ( mem_req  ),
    .mem_rsp  ( mem_rsp  )
  );

  tcdm_bank_sel i_bank_sel (
    .clk_i      ( clk_i      ),
    .arst_n     ( arst_n     ),
    .mem_req    ( mem_req    ),
    .mem_rsp    ( mem_rsp    ),
    .bank_req   ( bank_req   ),
    .bank_rdata ( bank_rdata )
  );

  tcdm_banks_wrap i_banks (
    .clk_i      ( clk_i      ),
    .bank_req   ( bank_req   ),
    .bank_rdata ( bank_rdata )
  );

endmodule

// File: tb_tcdm_lite.sv
// Drives tcdm_lite_top over its AXI4-Lite port with one transaction at a time
// Stimulus comes from a Galois LFSR and read data is checked against a byte model
`timescale 1ns/1ps

module tb_tcdm_lite;

  localparam int          CLK_HALF     = 4;
  localparam int          RESET_CYCLES = 16;
  localparam logic [31:0] LFSR_SEED    = 32'h116e6dea;
  localparam logic [31:0] LFSR_TAPS    = 32'h80200003;
  localparam int          N_FILL       = 64;
  localparam int          N_PICK       = 32;
  // Transactions of all tests together
  localparam int          N_TRANS      = 304;
  localparam int          TIMEOUT_CYC  = N_TRANS * 40 + 200;

  logic                clk;
  logic                arst_n;
  tcdm_pkg::axil_req_t axil_req;
  tcdm_pkg::axil_rsp_t axil_rsp;

  logic [31:0] lfsr;
  int          cycle_cnt = 0;
  string       cur_test;
  int          check_cnt;
  int          err_cnt;
  int          test_cnt;
  int          test_checks;
  int          test_errs;

  // Byte model of the memory
  // Known marks bytes written with OKAY
  logic [7:0]  model_mem [tcdm_pkg::MEM_BYTES];
  logic        model_known [tcdm_pkg::MEM_BYTES];
  logic [15:0] fill_addr [N_FILL];
  logic [15:0] pick_addr [N_PICK];

  tcdm_lite_top DUT (
    .clk_i    ( clk      ),
    .arst_n   ( arst_n   ),
    .axil_req ( axil_req ),
    .axil_rsp ( axil_rsp )
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #CLK_HALF clk = ~clk;
    end
  end

  // Run limit
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC)
    begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("*** FAILED ***");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Random numbers and checks
  //////////////////////////////////////////////////
  // One LFSR step per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
    return val;
  endfunction

  // Aligned word address inside the 4 KB
  function automatic logic [15:0] rand_word_addr();
    return 16'(rand_bits(10) << 2);
  endfunction

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    check_cnt++;
    test_checks++;
    assert (act === exp)
    else
    begin
      $display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
      err_cnt++;
      test_errs++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    check_cnt++;
    test_checks++;
    assert (cond === 1'b1)
    else
    begin
      $display("%s: %s", cur_test, msg);
      err_cnt++;
      test_errs++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_checks = 0;
    test_errs   = 0;
  endtask

  task automatic end_test();
    test_cnt++;
    $display("test %s finished: %0d checks, %0d errors", cur_test, test_checks, test_errs);
  endtask

  task automatic check_idle_outputs();
    check_true(!axil_rsp.aw_ready && !axil_rsp.w_ready && !axil_rsp.ar_ready &&
               !axil_rsp.b_valid && !axil_rsp.r_valid,
               "a ready or valid output was high before any request");
  endtask

  //////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////
  task automatic model_write(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    int base;
    base = int'(addr) & ~3;
    for (int b = 0; b < 4; b++)
    begin
      if (strb[b])
      begin
        model_mem[base + b]   = data[b*8 +: 8];
        model_known[base + b] = 1'b1;
      end
    end
  endtask

  // Mask covers only bytes that were ever written
  task automatic model_expect(input logic [15:0] addr, output logic [31:0] exp,
                              output logic [31:0] mask);
    int base;
    base = int'(addr) & ~3;
    exp  = '0;
    mask = '0;
    for (int b = 0; b < 4; b++)
    begin
      if (model_known[base + b])
      begin
        exp[b*8 +: 8]  = model_mem[base + b];
        mask[b*8 +: 8] = 8'hff;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // AXI4-Lite driver
  //////////////////////////////////////////////////
  task automatic check_held(input logic is_wr, input logic [1:0] resp,
                            input logic [31:0] data);
    if (is_wr)
    begin
      check_true(axil_rsp.b_valid, "b_valid dropped before b_ready");
      check_eq("held b_resp", 32'(resp), 32'(axil_rsp.b_resp));
    end
    else
    begin
      check_true(axil_rsp.r_valid, "r_valid dropped before r_ready");
      check_eq("held r_resp", 32'(resp), 32'(axil_rsp.r_resp));
      check_eq("held r_data", data, axil_rsp.r_data);
    end
  endtask

  // Waits for B or R, keeps ready low for stall cycles, then takes it
  task automatic take_response(input logic is_wr, input int stall,
                               output logic [1:0] resp, output logic [31:0] data);
    logic vld;
    vld = 1'b0;
    while (!vld)
    begin
      @(negedge clk);
      vld = is_wr ? axil_rsp.b_valid : axil_rsp.r_valid;
    end
    resp = is_wr ? axil_rsp.b_resp : axil_rsp.r_resp;
    data = axil_rsp.r_data;
    for (int k = 0; k < stall; k++)
    begin
      @(posedge clk);
      #1;
      // Offer new requests that the slave must leave alone
      axil_req.aw_valid = 1'b1;
      axil_req.w_valid  = 1'b1;
      axil_req.ar_valid = 1'b1;
      @(negedge clk);
      check_held(is_wr, resp, data);
      check_true(!axil_rsp.aw_ready && !axil_rsp.w_ready && !axil_rsp.ar_ready,
                 "slave raised a ready while a response was pending");
    end
    @(posedge clk);
    #1;
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    axil_req.ar_valid = 1'b0;
    axil_req.b_ready  = is_wr;
    axil_req.r_ready  = !is_wr;
    @(negedge clk);
    check_held(is_wr, resp, data);
    @(posedge clk);
    #1;
    axil_req.b_ready = 1'b0;
    axil_req.r_ready = 1'b0;
    @(negedge clk);
    check_true(!axil_rsp.b_valid && !axil_rsp.r_valid,
               "response stayed valid after it was accepted");
  endtask

  task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int stall,
                            output logic [1:0] resp);
    logic [31:0] rdata_unused;
    @(posedge clk);
    #1;
    axil_req.aw_valid = 1'b1;
    axil_req.aw_addr  = addr;
    axil_req.w_valid  = 1'b1;
    axil_req.w_data   = data;
    axil_req.w_strb   = strb;
    @(negedge clk);
    while (!axil_rsp.aw_ready)
    begin
      @(negedge clk);
    end
    check_true(axil_rsp.w_ready, "w_ready did not rise together with aw_ready");
    @(posedge clk);
    #1;
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    take_response(1'b1, stall, resp, rdata_unused);
  endtask

  task automatic axil_read(input logic [15:0] addr, input int stall,
                           output logic [1:0] resp, output logic [31:0] data);
    @(posedge clk);
    #1;
    axil_req.ar_valid = 1'b1;
    axil_req.ar_addr  = addr;
    @(negedge clk);
    while (!axil_rsp.ar_ready)
    begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    axil_req.ar_valid = 1'b0;
    take_response(1'b0, stall, resp, data);
  endtask

  // Transactions with expected values from the address map and the model
  task automatic write_check(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int stall);
    logic [1:0] resp;
    logic [1:0] exp_resp;
    exp_resp = (int'(addr) >= tcdm_pkg::MEM_BYTES) ? tcdm_pkg::RESP_DECERR
                                                   : tcdm_pkg::RESP_OKAY;
    axil_write(addr, data, strb, stall, resp);
    check_eq("b_resp", 32'(exp_resp), 32'(resp));
    if (exp_resp == tcdm_pkg::RESP_OKAY)
    begin
      model_write(addr, data, strb);
    end
  endtask

  task automatic read_check(input logic [15:0] addr, input int stall);
    logic [1:0]  resp;
    logic [1:0]  exp_resp;
    logic [31:0] data;
    logic [31:0] exp;
    logic [31:0] mask;
    exp_resp = (int'(addr) >= tcdm_pkg::MEM_BYTES) ? tcdm_pkg::RESP_DECERR
                                                   : tcdm_pkg::RESP_OKAY;
    axil_read(addr, stall, resp, data);
    check_eq("r_resp", 32'(exp_resp), 32'(resp));
    if (exp_resp == tcdm_pkg::RESP_OKAY)
    begin
      model_expect(addr, exp, mask);
      check_eq("r_data", exp, data & mask);
    end
    else
    begin
      // Error reads return zero
      check_eq("r_data", 32'h0, data);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial
  begin
    int          j;
    int          stall;
    logic [15:0] addr;
    logic [15:0] base;
    logic [31:0] data;
    logic [3:0]  strb;

    axil_req  = '0;
    arst_n    = 1'b0;
    lfsr      = LFSR_SEED;
    check_cnt = 0;
    err_cnt   = 0;
    test_cnt  = 0;
    for (int i = 0; i < tcdm_pkg::MEM_BYTES; i++)
    begin
      model_known[i] = 1'b0;
    end

    // Outputs quiet in and after reset
    start_test("reset_state");
    for (int c = 0; c < RESET_CYCLES; c++)
    begin
      @(negedge clk);
      check_idle_outputs();
    end
    @(posedge clk);
    #1;
    arst_n = 1'b1;
    for (int c = 0; c < 4; c++)
    begin
      @(negedge clk);
      check_idle_outputs();
    end
    end_test();

    start_test("full_word");
    for (int i = 0; i < N_FILL; i++)
    begin
      fill_addr[i] = rand_word_addr();
      data         = rand_bits(32);
      write_check(fill_addr[i], data, 4'hf, 0);
    end
    // Shuffle so the read order differs from the write order
    for (int i = N_FILL - 1; i > 0; i--)
    begin
      j            = int'(rand_bits(6)) % (i + 1);
      addr         = fill_addr[i];
      fill_addr[i] = fill_addr[j];
      fill_addr[j] = addr;
    end
    for (int i = 0; i < N_FILL; i++)
    begin
      read_check(fill_addr[i], 0);
    end
    end_test();

    // Partial writes over filled words
    start_test("byte_strobe");
    for (int i = 0; i < N_PICK; i++)
    begin
      j            = int'(rand_bits(6));
      pick_addr[i] = fill_addr[j];
      data         = rand_bits(32);
      strb         = 4'(rand_bits(4));
      write_check(pick_addr[i], data, strb, 0);
    end
    for (int i = 0; i < N_PICK; i++)
    begin
      read_check(pick_addr[i], 0);
    end
    end_test();

    // 16 consecutive words span every bank four times
    start_test("interleave");
    base = 16'(rand_bits(6) << 6);
    for (int i = 0; i < 16; i++)
    begin
      data = {8'(i), 24'(rand_bits(24))};
      write_check(base + 16'(i * 4), data, 4'hf, 0);
    end
    for (int i = 0; i < 16; i++)
    begin
      read_check(base + 16'(i * 4), 0);
    end
    end_test();

    start_test("decode_error");
    for (int i = 0; i < 16; i++)
    begin
      // Nonzero hi over the low bits of a filled word
      j    = int'(rand_bits(6));
      addr = {4'(1 + rand_bits(4) % 15), fill_addr[j][11:0]};
      if (rand_bits(1) == 32'd1)
      begin
        data = rand_bits(32);
        strb = 4'(rand_bits(4));
        write_check(addr, data, strb, 0);
      end
      else
      begin
        read_check(addr, 0);
      end
      // Aliased word must be as the model left it
      read_check(fill_addr[j], 0);
    end
    end_test();

    start_test("back_pressure");
    for (int i = 0; i < 48; i++)
    begin
      stall = int'(rand_bits(4));
      if (rand_bits(3) == 32'd0)
      begin
        addr = 16'(32'h1000 + rand_bits(16) % 32'hf000);
      end
      else if (rand_bits(1) == 32'd1)
      begin
        j    = int'(rand_bits(6));
        addr = fill_addr[j];
      end
      else
      begin
        addr = rand_word_addr();
      end
      if (rand_bits(1) == 32'd1)
      begin
        data = rand_bits(32);
        strb = 4'(rand_bits(4));
        write_check(addr, data, strb, stall);
      end
      else
      begin
        read_check(addr, stall);
      end
    end
    end_test();

    $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: tcdm_lite.f
tcdm_pkg.sv
tcdm_sram_bank.sv
tcdm_banks_wrap.sv
tcdm_bank_sel.sv
tcdm_axil_front.sv
tcdm_lite_top.sv
tb_tcdm_lite.sv

// File: run_sim.sh
#!/bin/sh
# Builds the tcdm_lite testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_tcdm_lite -f tcdm_lite.f -o sim_tcdm_lite \
  && ./obj_dir/sim_tcdm_lite > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -qF '*** PASSED ***' sim.log && echo "result: pass" \
  || { echo "result: fail"; exit 1; }
